/* vlog.f */
+incdir+rtl
rtl/ao_pkg.sv
rtl/ao_reg_if.sv
rtl/ao_apb_ctrl.sv
rtl/ao_gpio.sv
rtl/ao_power_seq.sv
rtl/ao_irq_ctrl.sv
rtl/ao_top.sv
sim/tb_ao_top.sv

/* Bender.yml */
package:
  name: ao_top

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/ao_pkg.sv
      - rtl/ao_reg_if.sv
      - rtl/ao_apb_ctrl.sv
      - rtl/ao_gpio.sv
      - rtl/ao_power_seq.sv
      - rtl/ao_irq_ctrl.sv
      - rtl/ao_top.sv
  - target: simulation
    include_dirs:
      - rtl
    files:
      - sim/tb_ao_top.sv

/* sim/tb_ao_top.sv */
// ==========================================================================
// Table-driven testbench for the always-on block. Drives APB on the
// falling edge, models the power switches and checks the step order.
// ==========================================================================
`timescale 1ns/1ps
`default_nettype none

`include "ao_consts.svh"

module tb_ao_top;

  typedef enum {OP_WRITE, OP_READ, OP_PINS, OP_WAIT_PWR, OP_OUTPUT, OP_STEPS} op_e;

  typedef struct {
    op_e               op;
    ao_pkg::apb_addr_t addr;
    ao_pkg::reg_data_t data;
    ao_pkg::reg_data_t exp;
    ao_pkg::reg_data_t mask;
  } row_t;

  // OP_OUTPUT picks the pin group by its addr field
  localparam int OUT_IRQ     = 0;
  localparam int OUT_GPIO    = 1;
  localparam int OUT_GPIO_OE = 2;

  logic                clk_i;
  logic                rst_n_i;
  logic                psel_i;
  logic                penable_i;
  logic                pwrite_i;
  ao_pkg::apb_addr_t   paddr_i;
  ao_pkg::reg_data_t   pwdata_i;
  ao_pkg::reg_data_t   prdata_o;
  logic                pready_o;
  logic                pslverr_o;
  ao_pkg::gpio_vec_t   gpio_i;
  ao_pkg::gpio_vec_t   gpio_o;
  ao_pkg::gpio_vec_t   gpio_oe_o;
  ao_pkg::domain_vec_t pwr_switch_no;
  ao_pkg::domain_vec_t pwr_switch_ack_ni = '1;
  ao_pkg::domain_vec_t pwr_iso_no;
  ao_pkg::domain_vec_t pwr_rst_no;
  ao_pkg::domain_vec_t pwr_clkgate_en_no;
  logic                irq_o;

  row_t   rows[$];
  int     errors = 0;
  int     cycles = 0;
  integer seed = 32'hbda0c023;
  int     ack_wait [`AO_NUM_DOMAINS] = '{default: 0};
  // domain 1 step codes in upper case for a fall and lower case for a rise
  string      fall_codes = "CIRS";
  string      rise_codes = "cirs";
  string      step_log = "";
  logic [3:0] dom1_prev = '1;
  logic [3:0] dom1_now;

  ao_top DUT (.*);

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    cycles = cycles + 1;
    if (cycles > rows.size() * 40 + 100) begin
      $display("timeout: run stopped after %0d cycles", cycles);
      $display("errors: %0d", errors);
      $display("ERRORS FOUND");
      $finish;
    end
  end

  // ack follows the switch after 1 to 4 cycles
  always @(negedge clk_i) begin
    for (int d = 0; d < `AO_NUM_DOMAINS; d++) begin
      if (pwr_switch_ack_ni[d] == pwr_switch_no[d]) begin
        ack_wait[d] = 0;
      end else if (ack_wait[d] == 0) begin
        ack_wait[d] = 1 + ($unsigned($random(seed)) % 4);
      end else if (ack_wait[d] == 1) begin
        pwr_switch_ack_ni[d] = pwr_switch_no[d];
        ack_wait[d] = 0;
      end else begin
        ack_wait[d] = ack_wait[d] - 1;
      end
    end
  end

  // power step monitor
  always @(negedge clk_i) begin
    dom1_now = {pwr_switch_no[1], pwr_rst_no[1], pwr_iso_no[1], pwr_clkgate_en_no[1]};
    if (rst_n_i) begin
      for (int i = 0; i < 4; i++) begin
        if (dom1_prev[i] && !dom1_now[i]) begin
          step_log = {step_log, fall_codes.substr(i, i)};
        end
        if (!dom1_prev[i] && dom1_now[i]) begin
          step_log = {step_log, rise_codes.substr(i, i)};
        end
      end
      if ({pwr_switch_no[0], pwr_rst_no[0], pwr_iso_no[0], pwr_clkgate_en_no[0]} !== 4'hf) begin
        errors++;
        $display("[ERROR] %0t domain 0 sw/rst/iso/clk got %b%b%b%b expected 1111", $time,
                 pwr_switch_no[0], pwr_rst_no[0], pwr_iso_no[0], pwr_clkgate_en_no[0]);
      end
    end
    dom1_prev = dom1_now;
  end

  function automatic ao_pkg::apb_addr_t reg_addr(input int blk, input int idx);
    return ao_pkg::apb_addr_t'((blk << `AO_BLK_LO) | (idx << `AO_IDX_LO));
  endfunction

  task automatic add_row(input op_e op, input ao_pkg::apb_addr_t addr,
                         input ao_pkg::reg_data_t data, input ao_pkg::reg_data_t exp,
                         input ao_pkg::reg_data_t mask);
    row_t r;
    r.op   = op;
    r.addr = addr;
    r.data = data;
    r.exp  = exp;
    r.mask = mask;
    rows.push_back(r);
  endtask

  task automatic compare_value(input string name, input ao_pkg::reg_data_t got,
                               input ao_pkg::reg_data_t exp, input ao_pkg::reg_data_t mask);
    if ((got & mask) !== (exp & mask)) begin
      errors++;
      $display("[ERROR] %0t %s got 0x%0h expected 0x%0h", $time, name, got & mask, exp & mask);
    end
  endtask

  // starts and ends on a falling edge
  task automatic apb_transfer(input logic write, input ao_pkg::apb_addr_t addr,
                              input ao_pkg::reg_data_t wdata,
                              output ao_pkg::reg_data_t rdata, output logic slverr);
    int waited;
    waited    = 0;
    psel_i    = 1'b1;
    penable_i = 1'b0;
    pwrite_i  = write;
    paddr_i   = addr;
    pwdata_i  = wdata;
    @(negedge clk_i);
    penable_i = 1'b1;
    // responses are taken at the edge that ends the access cycle
    @(posedge clk_i);
    while (pready_o !== 1'b1 && waited < 8) begin
      @(posedge clk_i);
      waited++;
    end
    if (pready_o !== 1'b1) begin
      errors++;
      $display("APB transfer to 0x%03h never saw pready_o", addr);
    end
    rdata = prdata_o;
    slverr = pslverr_o;
    @(negedge clk_i);
    psel_i    = 1'b0;
    penable_i = 1'b0;
    pwrite_i  = 1'b0;
  endtask

  task automatic poll_power_status(input ao_pkg::reg_data_t exp, input ao_pkg::reg_data_t mask);
    ao_pkg::reg_data_t rdata;
    logic              slverr;
    int                polls;
    polls = 0;
    rdata = '1;
    while (((rdata & mask) !== (exp & mask)) && polls < 30) begin
      apb_transfer(1'b0, reg_addr(`AO_BLK_PWR, `AO_REG_PWR_STATUS), '0, rdata, slverr);
      polls++;
    end
    if ((rdata & mask) !== (exp & mask)) begin
      errors++;
      $display("PWR_STATUS never reached 0x%0h within %0d reads, last 0x%0h", exp, polls, rdata);
    end
  endtask

  task automatic match_step_log(input logic power_up);
    string expected;
    expected = power_up ? "sric" : "CIRS";
    if (step_log != expected) begin
      errors++;
      $display("domain 1 %s steps out of order: saw '%s', expected '%s'",
               power_up ? "power-up" : "power-down", step_log, expected);
    end
    step_log = "";
  endtask

  task automatic verify_reset_outputs();
    compare_value("pready_o", pready_o, 0, '1);
    compare_value("pslverr_o", pslverr_o, 0, '1);
    compare_value("irq_o", irq_o, 0, '1);
    compare_value("gpio_o", gpio_o, 0, '1);
    compare_value("gpio_oe_o", gpio_oe_o, 0, '1);
    compare_value("pwr_switch_no", pwr_switch_no, '1, 32'h3);
    compare_value("pwr_iso_no", pwr_iso_no, '1, 32'h3);
    compare_value("pwr_rst_no", pwr_rst_no, '1, 32'h3);
    compare_value("pwr_clkgate_en_no", pwr_clkgate_en_no, '1, 32'h3);
  endtask

  task automatic apply_row(input row_t r);
    ao_pkg::reg_data_t rdata;
    logic              slverr;
    case (r.op)
      OP_WRITE: begin
        apb_transfer(1'b1, r.addr, r.data, rdata, slverr);
        compare_value($sformatf("pslverr_o @0x%03h", r.addr), slverr, r.exp, r.mask);
      end
      OP_READ: begin
        apb_transfer(1'b0, r.addr, '0, rdata, slverr);
        compare_value($sformatf("prdata_o @0x%03h", r.addr), rdata, r.exp, r.mask);
        compare_value($sformatf("pslverr_o @0x%03h", r.addr), slverr, 0, '1);
      end
      OP_PINS: begin
        gpio_i = r.data[`AO_GPIO_W-1:0];
        repeat (3) @(negedge clk_i);
      end
      OP_WAIT_PWR: poll_power_status(r.exp, r.mask);
      OP_OUTPUT: begin
        if (r.addr == OUT_IRQ) compare_value("irq_o", irq_o, r.exp, r.mask);
        else if (r.addr == OUT_GPIO) compare_value("gpio_o", gpio_o, r.exp, r.mask);
        else compare_value("gpio_oe_o", gpio_oe_o, r.exp, r.mask);
      end
      OP_STEPS: match_step_log(r.data[0]);
      default: ;
    endcase
  endtask

  task automatic load_table();
    add_row(OP_READ,     reg_addr(0, `AO_REG_GPIO_OUT),   0, 0, '1);
    add_row(OP_READ,     reg_addr(1, `AO_REG_IRQ_STATUS), 0, 0, '1);
    add_row(OP_READ,     reg_addr(2, `AO_REG_PWR_STATUS), 0, 0, '1);
    add_row(OP_WRITE,    reg_addr(0, `AO_REG_GPIO_OUT),   32'ha5, 0, 1);
    add_row(OP_OUTPUT,   OUT_GPIO,                        0, 32'ha5, '1);
    add_row(OP_WRITE,    reg_addr(0, `AO_REG_GPIO_OE),    32'h0f, 0, 1);
    add_row(OP_OUTPUT,   OUT_GPIO_OE,                     0, 32'h0f, '1);
    add_row(OP_READ,     reg_addr(0, `AO_REG_GPIO_OE),    0, 32'h0f, '1);
    add_row(OP_READ,     reg_addr(0, 3),                  0, 0, '1);
    add_row(OP_PINS,     0,                               32'h3c, 0, 0);
    add_row(OP_READ,     reg_addr(0, `AO_REG_GPIO_IN),    0, 32'h3c, '1);
    add_row(OP_READ,     reg_addr(1, `AO_REG_IRQ_STATUS), 0, 32'h03c, '1);
    add_row(OP_OUTPUT,   OUT_IRQ,                         0, 0, 1);
    add_row(OP_WRITE,    reg_addr(1, `AO_REG_IRQ_STATUS), 32'h03c, 0, 1);
    add_row(OP_WRITE,    reg_addr(1, `AO_REG_IRQ_ENABLE), 32'h002, 0, 1);
    add_row(OP_PINS,     0,                               32'h3d, 0, 0);
    add_row(OP_READ,     reg_addr(1, `AO_REG_IRQ_STATUS), 0, 32'h001, '1);
    add_row(OP_OUTPUT,   OUT_IRQ,                         0, 0, 1);
    add_row(OP_WRITE,    reg_addr(1, `AO_REG_IRQ_ENABLE), 32'h001, 0, 1);
    add_row(OP_OUTPUT,   OUT_IRQ,                         0, 1, 1);
    add_row(OP_WRITE,    reg_addr(1, `AO_REG_IRQ_STATUS), 32'h001, 0, 1);
    add_row(OP_OUTPUT,   OUT_IRQ,                         0, 0, 1);
    add_row(OP_READ,     reg_addr(1, `AO_REG_IRQ_STATUS), 0, 0, '1);
    // domain 1 down and back up
    add_row(OP_WRITE,    reg_addr(2, `AO_REG_PWR_CTRL),   32'h2, 0, 1);
    add_row(OP_WAIT_PWR, 0,                               0, 32'h2, 32'h3);
    add_row(OP_STEPS,    0,                               0, 0, 0);
    add_row(OP_READ,     reg_addr(1, `AO_REG_IRQ_STATUS), 0, 32'h200, 32'h200);
    add_row(OP_WRITE,    reg_addr(2, `AO_REG_PWR_CTRL),   32'h0, 0, 1);
    add_row(OP_WAIT_PWR, 0,                               0, 32'h0, 32'h3);
    add_row(OP_STEPS,    0,                               1, 0, 0);
    // unmapped block 3
    add_row(OP_WRITE,    reg_addr(3, 0),                  32'hff, 1, 1);
    add_row(OP_READ,     reg_addr(0, `AO_REG_GPIO_OUT),   0, 32'ha5, '1);
  endtask

  initial begin
    rst_n_i   = 1'b0;
    psel_i    = 1'b0;
    penable_i = 1'b0;
    pwrite_i  = 1'b0;
    paddr_i   = '0;
    pwdata_i  = '0;
    gpio_i    = '0;
    load_table();
    repeat (10) @(negedge clk_i);
    rst_n_i = 1'b1;
    verify_reset_outputs();
    foreach (rows[i]) begin
      apply_row(rows[i]);
    end
    repeat (2) @(negedge clk_i);
    $display("errors: %0d", errors);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* rtl/ao_top.sv */
// ==========================================================================
// Always-on block top level. APB slave with GPIO, power sequencing of two
// domains and one interrupt line; all ports are plain signals.
// ==========================================================================
`timescale 1ns/1ps
`default_nettype none

module ao_top (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  logic                psel_i,
  input  logic                penable_i,
  input  logic                pwrite_i,
  input  ao_pkg::apb_addr_t   paddr_i,
  input  ao_pkg::reg_data_t   pwdata_i,
  output ao_pkg::reg_data_t   prdata_o,
  output logic                pready_o,
  output logic                pslverr_o,
  input  ao_pkg::gpio_vec_t   gpio_i,
  output ao_pkg::gpio_vec_t   gpio_o,
  output ao_pkg::gpio_vec_t   gpio_oe_o,
  output ao_pkg::domain_vec_t pwr_switch_no,
  input  ao_pkg::domain_vec_t pwr_switch_ack_ni,
  output ao_pkg::domain_vec_t pwr_iso_no,
  output ao_pkg::domain_vec_t pwr_rst_no,
  output ao_pkg::domain_vec_t pwr_clkgate_en_no,
  output logic                irq_o
);

  ao_reg_if gpio_bus ();
  ao_reg_if irq_bus ();
  ao_reg_if pwr_bus ();

  ao_pkg::gpio_vec_t   gpio_rise;
  ao_pkg::domain_vec_t pwr_done;

  ao_apb_ctrl u_apb_ctrl (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .psel_i    (psel_i),
    .penable_i (penable_i),
    .pwrite_i  (pwrite_i),
    .paddr_i   (paddr_i),
    .pwdata_i  (pwdata_i),
    .prdata_o  (prdata_o),
    .pready_o  (pready_o),
    .pslverr_o (pslverr_o),
    .gpio_bus  (gpio_bus.ctrl),
    .irq_bus   (irq_bus.ctrl),
    .pwr_bus   (pwr_bus.ctrl)
  );

  ao_gpio u_gpio (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .gpio_i      (gpio_i),
    .gpio_o      (gpio_o),
    .gpio_oe_o   (gpio_oe_o),
    .gpio_rise_o (gpio_rise),
    .bus         (gpio_bus.blk)
  );

  ao_power_seq u_power_seq (
    .clk_i             (clk_i),
    .rst_n_i           (rst_n_i),
    .pwr_switch_ack_ni (pwr_switch_ack_ni),
    .pwr_switch_no     (pwr_switch_no),
    .pwr_iso_no        (pwr_iso_no),
    .pwr_rst_no        (pwr_rst_no),
    .pwr_clkgate_en_no (pwr_clkgate_en_no),
    .pwr_done_o        (pwr_done),
    .bus               (pwr_bus.blk)
  );

  ao_irq_ctrl u_irq_ctrl (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .gpio_rise_i (gpio_rise),
    .pwr_done_i  (pwr_done),
    .irq_o       (irq_o),
    .bus         (irq_bus.blk)
  );

endmodule

`default_nettype wire

/* rtl/ao_irq_ctrl.sv */
// ==========================================================================
// Interrupt collector. Event pulses set sticky status bits, software
// clears them by writing ones; enabled bits drive irq_o.
// ==========================================================================
`timescale 1ns/1ps
`default_nettype none

`include "ao_consts.svh"

module ao_irq_ctrl (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  ao_pkg::gpio_vec_t   gpio_rise_i,
  input  ao_pkg::domain_vec_t pwr_done_i,
  output logic                irq_o,
  ao_reg_if.blk               bus
);

  ao_pkg::irq_vec_t events;
  ao_pkg::irq_vec_t clr;
  ao_pkg::irq_vec_t status_q;
  ao_pkg::irq_vec_t enable_q;

  assign events = {pwr_done_i, gpio_rise_i};

  always_comb begin
    clr = '0;
    if (bus.sel && bus.we && bus.idx == `AO_REG_IRQ_STATUS) begin
      clr = bus.wdata[`AO_IRQ_W-1:0];
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      status_q <= '0;
      enable_q <= '0;
    end else begin
      // a new event beats a clear in the same cycle
      status_q <= (status_q & ~clr) | events;
      if (bus.sel && bus.we && bus.idx == `AO_REG_IRQ_ENABLE) begin
        enable_q <= bus.wdata[`AO_IRQ_W-1:0];
      end
    end
  end

  assign irq_o = |(status_q & enable_q);

  always_comb begin
    bus.rdata = '0;
    case (bus.idx)
      `AO_REG_IRQ_STATUS: bus.rdata[`AO_IRQ_W-1:0] = status_q;
      `AO_REG_IRQ_ENABLE: bus.rdata[`AO_IRQ_W-1:0] = enable_q;
      default:            bus.rdata = '0;
    endcase
  end

endmodule

`default_nettype wire

/* rtl/ao_power_seq.sv */
// ==========================================================================
// Power sequencers for the switchable domains. PWR_CTRL holds the
// requested off state per domain, PWR_STATUS shows the domains that are off.
// ==========================================================================
`timescale 1ns/1ps
`default_nettype none

`include "ao_consts.svh"

module ao_power_seq (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  ao_pkg::domain_vec_t pwr_switch_ack_ni,
  output ao_pkg::domain_vec_t pwr_switch_no,
  output ao_pkg::domain_vec_t pwr_iso_no,
  output ao_pkg::domain_vec_t pwr_rst_no,
  output ao_pkg::domain_vec_t pwr_clkgate_en_no,
  output ao_pkg::domain_vec_t pwr_done_o,
  ao_reg_if.blk               bus
);

  ao_pkg::domain_vec_t req_q;
  ao_pkg::domain_vec_t off_vec;

  // requests that land mid-sequence wait here until ON or OFF
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      req_q <= '0;
    end else if (bus.sel && bus.we && bus.idx == `AO_REG_PWR_CTRL) begin
      req_q <= bus.wdata[`AO_NUM_DOMAINS-1:0];
    end
  end

  for (genvar d = 0; d < `AO_NUM_DOMAINS; d++) begin : g_dom
    ao_pkg::pwr_state_e state_q;
    ao_pkg::pwr_state_e state_d;
    logic sw_n_q;
    logic iso_n_q;
    logic rst_n_q;
    logic clk_n_q;
    logic done_q;
    logic off_q;

    always_comb begin
      state_d = state_q;
      case (state_q)
        ao_pkg::ON:          if (req_q[d]) state_d = ao_pkg::CLK_OFF;
        ao_pkg::CLK_OFF:     state_d = ao_pkg::ISO_ON;
        ao_pkg::ISO_ON:      state_d = ao_pkg::RST_ON;
        ao_pkg::RST_ON:      state_d = ao_pkg::SW_OFF_WAIT;
        ao_pkg::SW_OFF_WAIT: if (!pwr_switch_ack_ni[d]) state_d = ao_pkg::OFF;
        ao_pkg::OFF:         if (!req_q[d]) state_d = ao_pkg::SW_ON_WAIT;
        ao_pkg::SW_ON_WAIT:  if (pwr_switch_ack_ni[d]) state_d = ao_pkg::RST_OFF;
        ao_pkg::RST_OFF:     state_d = ao_pkg::ISO_OFF;
        ao_pkg::ISO_OFF:     state_d = ao_pkg::CLK_ON;
        ao_pkg::CLK_ON:      state_d = ao_pkg::ON;
        default:             state_d = ao_pkg::ON;
      endcase
    end

    // outputs follow the state they enter with
    always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
        state_q <= ao_pkg::ON;
        sw_n_q  <= 1'b1;
        iso_n_q <= 1'b1;
        rst_n_q <= 1'b1;
        clk_n_q <= 1'b1;
        done_q  <= 1'b0;
        off_q   <= 1'b0;
      end else begin
        state_q <= state_d;
        clk_n_q <= state_d inside {ao_pkg::ON, ao_pkg::CLK_ON};
        iso_n_q <= state_d inside {ao_pkg::ON, ao_pkg::CLK_OFF, ao_pkg::ISO_OFF,
                                   ao_pkg::CLK_ON};
        rst_n_q <= !(state_d inside {ao_pkg::RST_ON, ao_pkg::SW_OFF_WAIT, ao_pkg::OFF,
                                     ao_pkg::SW_ON_WAIT});
        sw_n_q  <= !(state_d inside {ao_pkg::SW_OFF_WAIT, ao_pkg::OFF});
        done_q  <= (state_d != state_q) && (state_d inside {ao_pkg::ON, ao_pkg::OFF});
        if (state_d == ao_pkg::OFF) begin
          off_q <= 1'b1;
        end else if (state_d == ao_pkg::ON) begin
          off_q <= 1'b0;
        end
      end
    end

    assign pwr_switch_no[d]     = sw_n_q;
    assign pwr_iso_no[d]        = iso_n_q;
    assign pwr_rst_no[d]        = rst_n_q;
    assign pwr_clkgate_en_no[d] = clk_n_q;
    assign pwr_done_o[d]        = done_q;
    assign off_vec[d]           = off_q;

    a_iso_before_switch: assert property (
      @(posedge clk_i) disable iff (!rst_n_i) !sw_n_q |-> !iso_n_q
    );
    a_rst_release_powered: assert property (
      @(posedge clk_i) disable iff (!rst_n_i) $rose(rst_n_q) |-> sw_n_q
    );
  end

  always_comb begin
    bus.rdata = '0;
    case (bus.idx)
      `AO_REG_PWR_CTRL:   bus.rdata[`AO_NUM_DOMAINS-1:0] = req_q;
      `AO_REG_PWR_STATUS: bus.rdata[`AO_NUM_DOMAINS-1:0] = off_vec;
      default:            bus.rdata = '0;
    endcase
  end

endmodule

`default_nettype wire

/* rtl/ao_gpio.sv */
// ==========================================================================
// GPIO block: output and output-enable registers, two-flop input
// synchronizer and one-cycle rising-edge events for the interrupt block.
// ==========================================================================
`timescale 1ns/1ps
`default_nettype none

`include "ao_consts.svh"

module ao_gpio (
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  ao_pkg::gpio_vec_t gpio_i,
  output ao_pkg::gpio_vec_t gpio_o,
  output ao_pkg::gpio_vec_t gpio_oe_o,
  output ao_pkg::gpio_vec_t gpio_rise_o,
  ao_reg_if.blk             bus
);

  ao_pkg::gpio_vec_t out_q;
  ao_pkg::gpio_vec_t oe_q;
  ao_pkg::gpio_vec_t meta_q;
  ao_pkg::gpio_vec_t sync_q;
  ao_pkg::gpio_vec_t prev_q;
  ao_pkg::gpio_vec_t rise_q;
  logic              wr_en;

  assign wr_en = bus.sel && bus.we;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      out_q <= '0;
      oe_q  <= '0;
    end else if (wr_en) begin
      if (bus.idx == `AO_REG_GPIO_OUT) begin
        out_q <= bus.wdata[`AO_GPIO_W-1:0];
      end
      if (bus.idx == `AO_REG_GPIO_OE) begin
        oe_q <= bus.wdata[`AO_GPIO_W-1:0];
      end
    end
  end

  // pins are asynchronous to clk_i
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      meta_q <= '0;
      sync_q <= '0;
      prev_q <= '0;
      rise_q <= '0;
    end else begin
      meta_q <= gpio_i;
      sync_q <= meta_q;
      prev_q <= sync_q;
      rise_q <= sync_q & ~prev_q;
    end
  end

  assign gpio_o      = out_q;
  assign gpio_oe_o   = oe_q;
  assign gpio_rise_o = rise_q;

  always_comb begin
    bus.rdata = '0;
    case (bus.idx)
      `AO_REG_GPIO_OUT: bus.rdata[`AO_GPIO_W-1:0] = out_q;
      `AO_REG_GPIO_OE:  bus.rdata[`AO_GPIO_W-1:0] = oe_q;
      `AO_REG_GPIO_IN:  bus.rdata[`AO_GPIO_W-1:0] = sync_q;
      default:          bus.rdata = '0;
    endcase
  end

endmodule

`default_nettype wire

/* rtl/ao_apb_ctrl.sv */
// ==========================================================================
// APB slave front end. Decodes the block from the address and steers
// zero-wait-state transfers onto the three register buses.
// ==========================================================================
`timescale 1ns/1ps
`default_nettype none

`include "ao_consts.svh"

module ao_apb_ctrl (
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  logic              psel_i,
  input  logic              penable_i,
  input  logic              pwrite_i,
  input  ao_pkg::apb_addr_t paddr_i,
  input  ao_pkg::reg_data_t pwdata_i,
  output ao_pkg::reg_data_t prdata_o,
  output logic              pready_o,
  output logic              pslverr_o,
  ao_reg_if.ctrl            gpio_bus,
  ao_reg_if.ctrl            irq_bus,
  ao_reg_if.ctrl            pwr_bus
);

  logic                              access;
  logic [`AO_BLK_HI-`AO_BLK_LO:0]    blk;
  ao_pkg::reg_idx_t                  idx;
  logic                              mapped;

  assign access = psel_i && penable_i;
  assign blk    = paddr_i[`AO_BLK_HI:`AO_BLK_LO];
  assign idx    = paddr_i[`AO_IDX_HI:`AO_IDX_LO];
  assign mapped = (blk == `AO_BLK_GPIO) || (blk == `AO_BLK_IRQ) || (blk == `AO_BLK_PWR);

  // no wait states, so every access cycle completes
  assign pready_o  = access;
  assign pslverr_o = access && !mapped;

  assign gpio_bus.sel   = access && (blk == `AO_BLK_GPIO);
  assign gpio_bus.we    = pwrite_i;
  assign gpio_bus.idx   = idx;
  assign gpio_bus.wdata = pwdata_i;

  assign irq_bus.sel    = access && (blk == `AO_BLK_IRQ);
  assign irq_bus.we     = pwrite_i;
  assign irq_bus.idx    = idx;
  assign irq_bus.wdata  = pwdata_i;

  assign pwr_bus.sel    = access && (blk == `AO_BLK_PWR);
  assign pwr_bus.we     = pwrite_i;
  assign pwr_bus.idx    = idx;
  assign pwr_bus.wdata  = pwdata_i;

  always_comb begin
    case (blk)
      `AO_BLK_GPIO: prdata_o = gpio_bus.rdata;
      `AO_BLK_IRQ:  prdata_o = irq_bus.rdata;
      `AO_BLK_PWR:  prdata_o = pwr_bus.rdata;
      default:      prdata_o = '0;
    endcase
  end

  // every access cycle follows a setup cycle
  property p_ready_after_setup;
    @(posedge clk_i) disable iff (!rst_n_i)
      pready_o |-> penable_i && $past(psel_i && !penable_i);
  endproperty
  a_ready_after_setup: assert property (p_ready_after_setup);

  a_one_sel: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
      $onehot0({gpio_bus.sel, irq_bus.sel, pwr_bus.sel})
  );

endmodule

`default_nettype wire

/* rtl/ao_reg_if.sv */
// ==========================================================================
// Register access bus from the APB front end to one datapath block.
// sel is high for the access cycle only; rdata is combinational.
// ==========================================================================
`timescale 1ns/1ps
`default_nettype none

interface ao_reg_if;

  logic              sel;
  logic              we;
  ao_pkg::reg_idx_t  idx;
  ao_pkg::reg_data_t wdata;
  ao_pkg::reg_data_t rdata;

  modport ctrl (
    output sel,
    output we,
    output idx,
    output wdata,
    input  rdata
  );

  modport blk (
    input  sel,
    input  we,
    input  idx,
    input  wdata,
    output rdata
  );

endinterface

`default_nettype wire

/* rtl/ao_pkg.sv */
// ==========================================================================
// Shared types of the always-on block, referenced as ao_pkg::name.
// ==========================================================================
`default_nettype none

`include "ao_consts.svh"

package ao_pkg;

  typedef logic [`AO_ADDR_W-1:0]              apb_addr_t;
  typedef logic [`AO_DATA_W-1:0]              reg_data_t;
  typedef logic [`AO_IDX_HI-`AO_IDX_LO:0]     reg_idx_t;
  typedef logic [`AO_GPIO_W-1:0]              gpio_vec_t;
  typedef logic [`AO_NUM_DOMAINS-1:0]         domain_vec_t;
  // gpio events in 7:0, power done in 9:8
  typedef logic [`AO_IRQ_W-1:0]               irq_vec_t;

  // power-down runs ON to OFF, power-up runs back
  typedef enum logic [3:0] {
    ON,
    CLK_OFF,
    ISO_ON,
    RST_ON,
    SW_OFF_WAIT,
    OFF,
    SW_ON_WAIT,
    RST_OFF,
    ISO_OFF,
    CLK_ON
  } pwr_state_e;

endpackage

`default_nettype wire

/* rtl/ao_consts.svh */
// ==========================================================================
// Widths, block map and register indexes of the always-on block.
// Include this file wherever the macros are needed.
// ==========================================================================
`ifndef AO_CONSTS_SVH
`define AO_CONSTS_SVH

`define AO_ADDR_W      12
`define AO_DATA_W      32
`define AO_GPIO_W      8
`define AO_NUM_DOMAINS 2
`define AO_IRQ_W       (`AO_GPIO_W + `AO_NUM_DOMAINS)

// address fields: block in 5:4, register in 3:2
`define AO_BLK_HI 5
`define AO_BLK_LO 4
`define AO_IDX_HI 3
`define AO_IDX_LO 2

`define AO_BLK_GPIO 0
`define AO_BLK_IRQ  1
`define AO_BLK_PWR  2

`define AO_REG_GPIO_OUT    0
`define AO_REG_GPIO_OE     1
`define AO_REG_GPIO_IN     2
`define AO_REG_IRQ_STATUS  0
`define AO_REG_IRQ_ENABLE  1
`define AO_REG_PWR_CTRL    0
`define AO_REG_PWR_STATUS  1

`endif
